// File: Makefile
# Verilator build and run of the routing decision testbench

TOP = route_decision_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

obj_dir/V$(TOP): project.f common/wsn_config.svh common/wsn_pkg.sv node_mem/node_mem.sv \
		verilog/neighbor_scan.sv verilog/select_my_action.sv verilog/route_decision.sv \
		dv/route_decision_tb.sv
	verilator --binary --timing --assert -f project.f --top-module $(TOP)

test: obj_dir/V$(TOP)
	obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: common/wsn_config.svh
`ifndef WSN_CONFIG_SVH
`define WSN_CONFIG_SVH

// datapath and address widths
`define WORD_WIDTH 16
`define ADDR_WIDTH 11   // full address width, only the low bits reach the array
`define MEM_DEPTH 64    // words actually built in the node memory

// code reported when no neighbor qualifies
`define NO_NODE 65

// fixed words of the node table
`define MY_CLUSTER_ADDR 1
`define FLAG_ADDR 2     // aggregation flag, written by the action selector
`define COUNT_ADDR 3

// neighbor entries start here, four words each: id, cluster, route value, role
`define TABLE_BASE 16
`define MAX_NEIGHBORS 12   // keeps the last entry below MEM_DEPTH

`endif

// File: common/wsn_pkg.sv
`default_nettype none
`include "wsn_config.svh"

package wsn_pkg;

	typedef logic [`WORD_WIDTH-1:0] word_t;
	typedef logic [`ADDR_WIDTH-1:0] addr_t;

	// role word value that marks a sink, everything else is an ordinary node
	localparam word_t role_sink = word_t'(1);

	// neighbor scanner
	typedef enum logic [1:0] {
		idle,
		read_header,   // fetch own cluster and neighbor count
		fetch,         // stream the entries, one word per cycle
		finish
	} scan_state_t;

	// action selector
	typedef enum logic [2:0] {
		parked,
		wait_start,
		take_sink,
		take_hop,
		end_write,
		signal_done
	} action_state_t;

endpackage

`default_nettype wire

// File: dv/route_decision_tb.sv
`default_nettype none
`include "wsn_config.svh"

// table-driven testbench for the routing decision of one sensor node
module route_decision_tb import wsn_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int n_directed = 7;
	localparam int n_random = 24;
	localparam int n_cases = n_directed + n_random;
	localparam int case_cycles = 200;  // load, full scan, selector, hold checks and flag read
	localparam int done_limit = 120;   // cycles allowed from start to done

	// entry MAX_NEIGHBORS + 1 lands on these spare words once the scan address wraps
	localparam int decoy_addr = (`TABLE_BASE + 4 * (`MAX_NEIGHBORS + 1)) % `MEM_DEPTH;
	localparam int decoy_id = 900;

	// own cluster, count, expected action, expected flag,
	// then four entries of id, cluster, route value and role
	localparam int directed_tab [n_directed][20] = '{
		'{2, 3, 102, 0, 101, 1, 5, 0, 102, 2, 0, 1, 103, 3, 9, 0, 0, 0, 0, 0},
		'{2, 4, 111, 0, 110, 3, 7, 0, 111, 2, 0, 1, 112, 2, 0, 1, 113, 1, 8, 0},
		'{1, 4, 122, 0, 120, 1, 20, 0, 121, 2, 6, 0, 122, 3, 9, 0, 123, 0, 9, 1},
		'{1, 0, `NO_NODE, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0},
		'{0, 2, `NO_NODE, 1, 130, 0, 5, 0, 131, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0},
		'{3, 1, 140, 0, 140, 3, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0},
		'{1, 14, `NO_NODE, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0}
	};

	logic clock;
	logic nrst;
	logic start;
	logic host_wr_en;
	addr_t host_address;
	word_t host_wdata;
	word_t host_rdata;
	word_t action;
	logic for_aggregation;
	logic done;

	// the case currently applied
	word_t case_cluster;
	word_t case_count;
	word_t ent_id [`MAX_NEIGHBORS];
	word_t ent_cluster [`MAX_NEIGHBORS];
	word_t ent_route [`MAX_NEIGHBORS];
	word_t ent_role [`MAX_NEIGHBORS];

	logic [31:0] rng_state;
	int errors;
	int case_errors;
	int tests_passed;
	int tests_failed;

	route_decision dut0 (
		.clock(clock),
		.nrst(nrst),
		.start(start),
		.host_wr_en(host_wr_en),
		.host_address(host_address),
		.host_wdata(host_wdata),
		.host_rdata(host_rdata),
		.action(action),
		.for_aggregation(for_aggregation),
		.done(done)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	function automatic int unsigned rand_below(input int unsigned bound);
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return (rng_state >> 8) % bound;
	endfunction

	function automatic int clamped_count();
		if (case_count > word_t'(`MAX_NEIGHBORS)) begin
			return `MAX_NEIGHBORS;
		end
		return int'(case_count);
	endfunction

	// first same-cluster sink wins, else the strictly best other-cluster route above zero
	task automatic predict_decision(output word_t exp_action, output logic exp_agg);
		word_t sink_id;
		word_t hop_id;
		word_t best;
		logic sink_seen;
		sink_id = word_t'(`NO_NODE);
		hop_id = word_t'(`NO_NODE);
		best = '0;
		sink_seen = 1'b0;
		for (int i = 0; i < clamped_count(); i++) begin
			if (ent_cluster[i] == case_cluster) begin
				if (ent_role[i] == role_sink && !sink_seen) begin
					sink_seen = 1'b1;
					sink_id = ent_id[i];
				end
			end else if (ent_route[i] > best) begin
				best = ent_route[i];
				hop_id = ent_id[i];
			end
		end
		exp_action = sink_seen ? sink_id : hop_id;
		exp_agg = !sink_seen && hop_id == word_t'(`NO_NODE);
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		assert (got === exp) else begin
			$display("[ERROR] t=%0t %s: expected %0d, got %0d", $time, name, exp, got);
			case_errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		assert (got === exp) else begin
			$display("[ERROR] t=%0t %s: expected %0b, got %0b", $time, name, exp, got);
			case_errors++;
		end
	endtask

	task automatic write_word(input addr_t addr, input word_t data);
		@(posedge clock);
		host_wr_en <= 1'b1;
		host_address <= addr;
		host_wdata <= data;
	endtask

	task automatic read_word(input addr_t addr, output word_t data);
		@(posedge clock);
		host_address <= addr;
		@(posedge clock);
		@(negedge clock);   // host_rdata follows the address by one registered cycle
		data = host_rdata;
	endtask

	task automatic load_table();
		write_word(addr_t'(`MY_CLUSTER_ADDR), case_cluster);
		write_word(addr_t'(`COUNT_ADDR), case_count);
		write_word(addr_t'(`FLAG_ADDR), '0);
		// an in-cluster sink that only a scan past the clamp would reach
		write_word(addr_t'(decoy_addr), word_t'(decoy_id));
		write_word(addr_t'(decoy_addr + 1), case_cluster);
		write_word(addr_t'(decoy_addr + 2), '0);
		write_word(addr_t'(decoy_addr + 3), role_sink);
		for (int i = 0; i < clamped_count(); i++) begin
			write_word(addr_t'(`TABLE_BASE + 4 * i), ent_id[i]);
			write_word(addr_t'(`TABLE_BASE + 4 * i + 1), ent_cluster[i]);
			write_word(addr_t'(`TABLE_BASE + 4 * i + 2), ent_route[i]);
			write_word(addr_t'(`TABLE_BASE + 4 * i + 3), ent_role[i]);
		end
		@(posedge clock);
		host_wr_en <= 1'b0;
	endtask

	task automatic tally(input string what);
		if (case_errors == 0) begin
			tests_passed++;
			$display("%s: passed", what);
		end else begin
			tests_failed++;
			$display("%s: failed with %0d errors", what, case_errors);
		end
		errors += case_errors;
	endtask

	task automatic run_case(input int idx, input string kind, input word_t exp_action,
			input logic exp_agg);
		int cycles;
		word_t flag;
		case_errors = 0;
		load_table();
		@(posedge clock);
		start <= 1'b1;
		@(posedge clock);
		start <= 1'b0;
		@(negedge clock);
		check_bit("done", done, 1'b0);   // the previous result is withdrawn at once
		cycles = 0;
		while (!done && cycles < done_limit) begin
			@(negedge clock);
			cycles++;
		end
		assert (done) else begin
			$display("done did not rise within %0d cycles of start", done_limit);
			case_errors++;
		end
		check_word("action", action, exp_action);
		check_bit("for_aggregation", for_aggregation, exp_agg);
		// the outputs hold because a start gives exactly one result
		repeat (3) begin
			@(negedge clock);
			check_bit("done", done, 1'b1);
			check_word("action", action, exp_action);
		end
		read_word(addr_t'(`FLAG_ADDR), flag);
		check_word("flag word", flag, exp_agg ? word_t'(1) : word_t'(0));
		tally($sformatf("test %0d %s, cluster %0d count %0d, action %0d aggregation %0b",
			idx, kind, case_cluster, case_count, exp_action, exp_agg));
	endtask

	initial begin
		word_t exp_action;
		logic exp_agg;
		rng_state = 32'hbf922fcd;
		errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		nrst <= 1'b0;
		start <= 1'b0;
		host_wr_en <= 1'b0;
		host_address <= '0;
		host_wdata <= '0;
		repeat (5) @(posedge clock);
		nrst <= 1'b1;
		@(negedge clock);
		case_errors = 0;
		check_bit("done", done, 1'b0);
		check_bit("for_aggregation", for_aggregation, 1'b0);
		check_word("action", action, word_t'(`NO_NODE));
		tally("reset values");

		for (int k = 0; k < n_directed; k++) begin
			case_cluster = word_t'(directed_tab[k][0]);
			case_count = word_t'(directed_tab[k][1]);
			for (int i = 0; i < `MAX_NEIGHBORS; i++) begin
				ent_id[i] = '0;
				ent_cluster[i] = '0;
				ent_route[i] = '0;
				ent_role[i] = '0;
			end
			for (int i = 0; i < 4; i++) begin
				ent_id[i] = word_t'(directed_tab[k][4 + 4 * i]);
				ent_cluster[i] = word_t'(directed_tab[k][5 + 4 * i]);
				ent_route[i] = word_t'(directed_tab[k][6 + 4 * i]);
				ent_role[i] = word_t'(directed_tab[k][7 + 4 * i]);
			end
			run_case(k, "directed", word_t'(directed_tab[k][2]), directed_tab[k][3] != 0);
		end

		// counts up to 15 so the clamp at the table size is exercised
		for (int k = 0; k < n_random; k++) begin
			case_cluster = word_t'(rand_below(3));
			case_count = word_t'(rand_below(16));
			for (int i = 0; i < `MAX_NEIGHBORS; i++) begin
				ent_id[i] = word_t'(200 + rand_below(300));
				ent_cluster[i] = word_t'(rand_below(3));
				ent_route[i] = word_t'(rand_below(8));
				ent_role[i] = word_t'(rand_below(6));
			end
			predict_decision(exp_action, exp_agg);
			run_case(n_directed + k, "random", exp_action, exp_agg);
		end

		$display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
			tests_passed + tests_failed, tests_passed, tests_failed, errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

	// budget covers every case at its longest plus the reset phase
	initial begin
		#((n_cases + 1) * case_cycles * 10 + 100);
		$display("watchdog: the tests did not complete within their time budget");
		$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: node_mem/node_mem.sv
`default_nettype none
`include "wsn_config.svh"

// two-port node table, the host loads it and the routing engine reads and updates it
module node_mem import wsn_pkg::*; (
	input logic clock,
	input logic host_wr_en,
	input addr_t host_address,
	input word_t host_wdata,
	output word_t host_rdata,
	input addr_t scan_address,
	output word_t mem_rdata,
	input logic wr_en,
	input addr_t address,
	input word_t data_out
);

	localparam int idx_width = $clog2(`MEM_DEPTH);

	word_t mem [`MEM_DEPTH];

	logic [idx_width-1:0] host_idx;
	logic [idx_width-1:0] scan_idx;
	logic [idx_width-1:0] eng_idx;

	// only the low address bits select a word
	assign host_idx = host_address[idx_width-1:0];
	assign scan_idx = scan_address[idx_width-1:0];
	assign eng_idx = address[idx_width-1:0];

	always_ff @(posedge clock) begin
		if (host_wr_en) begin
			mem[host_idx] <= host_wdata;
		end
		// the engine write comes last so it wins a same-address collision
		if (wr_en) begin
			mem[eng_idx] <= data_out;
		end
	end

	// registered reads, a write shows up on the following cycle
	always_ff @(posedge clock) begin
		host_rdata <= mem[host_idx];
		mem_rdata <= mem[scan_idx];
	end

endmodule

`default_nettype wire

// File: project.f
+incdir+common
common/wsn_pkg.sv
node_mem/node_mem.sv
verilog/neighbor_scan.sv
verilog/select_my_action.sv
verilog/route_decision.sv
dv/route_decision_tb.sv

// File: verilog/neighbor_scan.sv
`default_nettype none
`include "wsn_config.svh"

// walks the neighbor entries and keeps the in-cluster sink and the best out-of-cluster hop
module neighbor_scan import wsn_pkg::*; (
	input logic clock,
	input logic nrst,
	input logic start,
	output addr_t scan_address,
	input word_t mem_rdata,
	output word_t next_sink,
	output word_t next_hop,
	output logic done
);

	scan_state_t state;
	logic [1:0] hdr_step;      // which header word is on the read port
	logic [7:0] total_words;   // four words per neighbor after clamping
	logic [7:0] issue_idx;
	logic [7:0] rx_idx;
	logic rx_valid;            // mem_rdata carries a table word this cycle
	logic issuing;
	logic sink_found;
	word_t my_cluster;
	word_t cur_id;
	word_t cur_cluster;
	word_t cur_route;
	word_t best_route;

	assign issuing = (state == fetch) && (issue_idx < total_words);

	// the address is presented in the cycle the counter points at it
	always_comb begin
		case (state)
			read_header: begin
				if (hdr_step == 2'd0) begin
					scan_address = addr_t'(`MY_CLUSTER_ADDR);
				end else begin
					scan_address = addr_t'(`COUNT_ADDR);
				end
			end
			fetch: scan_address = addr_t'(`TABLE_BASE) + addr_t'(issue_idx);
			default: scan_address = addr_t'(`MY_CLUSTER_ADDR);
		endcase
	end

	always_ff @(posedge clock) begin
		if (!nrst) begin
			state <= idle;
			hdr_step <= 2'd0;
			total_words <= 8'd0;
			issue_idx <= 8'd0;
			rx_idx <= 8'd0;
			rx_valid <= 1'b0;
			sink_found <= 1'b0;
			next_sink <= word_t'(`NO_NODE);
			next_hop <= word_t'(`NO_NODE);
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				idle: begin
					if (start) begin // a start while busy is simply not looked at
						hdr_step <= 2'd0;
						sink_found <= 1'b0;
						best_route <= '0; // a hop needs a route value above zero
						next_sink <= word_t'(`NO_NODE);
						next_hop <= word_t'(`NO_NODE);
						state <= read_header;
					end
				end
				read_header: begin
					hdr_step <= hdr_step + 2'd1;
					if (hdr_step == 2'd1) begin
						my_cluster <= mem_rdata;
					end
					if (hdr_step == 2'd2) begin // count is on the read port now
						if (mem_rdata > word_t'(`MAX_NEIGHBORS)) begin
							total_words <= 8'(`MAX_NEIGHBORS * 4);
						end else begin
							total_words <= {mem_rdata[5:0], 2'b00};
						end
						issue_idx <= 8'd0;
						rx_idx <= 8'd0;
						rx_valid <= 1'b0;
						state <= (mem_rdata == '0) ? finish : fetch;
					end
				end
				fetch: begin
					rx_valid <= issuing;
					if (issuing) begin
						issue_idx <= issue_idx + 8'd1;
					end
					if (rx_valid) begin // consume the word issued one cycle earlier
						rx_idx <= rx_idx + 8'd1;
						case (rx_idx[1:0])
							2'd0: cur_id <= mem_rdata;
							2'd1: cur_cluster <= mem_rdata;
							2'd2: cur_route <= mem_rdata;
							default: begin
								// role word closes the entry, so judge it here
								if (cur_cluster == my_cluster && mem_rdata == role_sink &&
										!sink_found) begin
									sink_found <= 1'b1;
									next_sink <= cur_id;
								end
								if (cur_cluster != my_cluster && cur_route > best_route) begin
									best_route <= cur_route; // strict compare keeps the earliest on a tie
									next_hop <= cur_id;
								end
							end
						endcase
						if (rx_idx == total_words - 8'd1) begin
							state <= finish;
						end
					end
				end
				finish: begin
					done <= 1'b1;
					state <= idle;
				end
				default: state <= idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/route_decision.sv
`default_nettype none

// routing decision of one sensor node: table memory, neighbor scan and action select
module route_decision import wsn_pkg::*; (
	input logic clock,
	input logic nrst,
	input logic start,
	input logic host_wr_en,
	input addr_t host_address,
	input word_t host_wdata,
	output word_t host_rdata,
	output word_t action,
	output logic for_aggregation,
	output logic done
);

	addr_t scan_address;
	word_t mem_rdata;
	word_t next_sink;
	word_t next_hop;
	logic scan_done;
	logic eng_wr_en;    // selector write into the flag word
	addr_t eng_address;
	word_t eng_data;

	node_mem mem0 (
		.clock(clock),
		.host_wr_en(host_wr_en),
		.host_address(host_address),
		.host_wdata(host_wdata),
		.host_rdata(host_rdata),
		.scan_address(scan_address),
		.mem_rdata(mem_rdata),
		.wr_en(eng_wr_en),
		.address(eng_address),
		.data_out(eng_data)
	);

	neighbor_scan scan0 (
		.clock(clock),
		.nrst(nrst),
		.start(start),
		.scan_address(scan_address),
		.mem_rdata(mem_rdata),
		.next_sink(next_sink),
		.next_hop(next_hop),
		.done(scan_done)
	);

	// the same start pulse rearms the selector while the scan runs
	select_my_action select0 (
		.clock(clock),
		.nrst(nrst),
		.en(start),
		.start(scan_done),
		.address(eng_address),
		.wr_en(eng_wr_en),
		.next_hop(next_hop),
		.next_sink(next_sink),
		.action(action),
		.data_out(eng_data),
		.for_aggregation(for_aggregation),
		.done(done)
	);

endmodule

`default_nettype wire

// File: verilog/select_my_action.sv
`default_nettype none
`include "wsn_config.svh"

// picks the action from the scan results: in-cluster sink first, then best hop,
// otherwise schedule aggregation and raise the flag word
module select_my_action import wsn_pkg::*; (
	input logic clock,
	input logic nrst,
	input logic en,
	input logic start,
	output addr_t address,
	output logic wr_en,
	input word_t next_hop,
	input word_t next_sink,
	output word_t action,
	output word_t data_out,
	output logic for_aggregation,
	output logic done
);

	action_state_t state;

	always_ff @(posedge clock) begin
		if (!nrst) begin
			state <= parked;
			done <= 1'b0;
			wr_en <= 1'b0;
			for_aggregation <= 1'b0;
			address <= '0;
			data_out <= '0;
			action <= word_t'(`NO_NODE);
		end else begin
			case (state)
				parked: begin
					if (en) begin // rearm and clear the previous decision
						done <= 1'b0;
						wr_en <= 1'b0;
						for_aggregation <= 1'b0;
						address <= '0;
						data_out <= '0;
						action <= word_t'(`NO_NODE);
						state <= wait_start;
					end
				end
				wait_start: begin
					if (start) begin
						state <= take_sink;
					end
				end
				take_sink: begin
					if (next_sink != word_t'(`NO_NODE)) begin
						action <= next_sink;
					end
					state <= take_hop;
				end
				take_hop: begin
					if (next_hop == word_t'(`NO_NODE) && next_sink == word_t'(`NO_NODE)) begin
						// nobody to forward to, so this node aggregates
						for_aggregation <= 1'b1;
						address <= addr_t'(`FLAG_ADDR);
						data_out <= word_t'(1);
						wr_en <= 1'b1;
					end else if (next_sink == word_t'(`NO_NODE)) begin
						action <= next_hop; // a sink taken above keeps priority
					end
					state <= end_write;
				end
				end_write: begin
					wr_en <= 1'b0;   // flag write lasts a single cycle
					state <= signal_done;
				end
				signal_done: begin
					done <= 1'b1;
					state <= parked;
				end
				default: state <= parked;
			endcase
		end
	end

endmodule

`default_nettype wire
